// ==== common/dbg_mem_pkg.sv ====
package dbg_mem_pkg;

  // --------------------------------------------------
  // sizes
  // --------------------------------------------------
  localparam int nr_harts      = 4;
  localparam int hartsel_w     = 2;
  localparam int data_count    = 2;
  localparam int progbuf_size  = 4;
  localparam int abs_cmd_words = 10;
  localparam int dbg_addr_w    = 12;

  // --------------------------------------------------
  // address map, low 12 bits of the hart address
  // --------------------------------------------------
  // hart event writes
  localparam logic [dbg_addr_w-1:0] halted_addr    = 12'h100;
  localparam logic [dbg_addr_w-1:0] going_addr     = 12'h104;
  localparam logic [dbg_addr_w-1:0] resuming_addr  = 12'h108;
  localparam logic [dbg_addr_w-1:0] exception_addr = 12'h10C;

  // jump slot polled by the park loop
  localparam logic [dbg_addr_w-1:0] whereto_addr   = 12'h300;

  // abstract command program sits right below the program buffer
  localparam logic [dbg_addr_w-1:0] abs_cmd_addr   = 12'h348;
  localparam logic [dbg_addr_w-1:0] abs_cmd_end    = abs_cmd_addr + 12'(4 * abs_cmd_words - 1);
  localparam logic [dbg_addr_w-1:0] progbuf_addr   = 12'h370;
  localparam logic [dbg_addr_w-1:0] progbuf_end    = progbuf_addr + 12'(4 * progbuf_size - 1);
  localparam logic [dbg_addr_w-1:0] data_addr      = 12'h380;
  localparam logic [dbg_addr_w-1:0] data_end       = data_addr + 12'(4 * data_count - 1);

  // one flag byte per hart
  localparam logic [dbg_addr_w-1:0] flags_addr     = 12'h400;
  localparam logic [dbg_addr_w-1:0] flags_end      = 12'h7FF;

  // entry of the resume routine
  localparam logic [dbg_addr_w-1:0] resume_addr    = 12'h808;

  // --------------------------------------------------
  // abstract commands
  // --------------------------------------------------
  typedef struct packed {
    logic [7:0]  cmdtype;
    logic [23:0] control;
  } cmd_t;

  // access register view of cmd_t.control
  typedef struct packed {
    logic        reserved;
    logic [2:0]  aarsize;
    logic        aarpostincrement;
    logic        postexec;
    logic        transfer;
    logic        write;
    logic [15:0] regno;
  } ac_ar_cmd_t;

  localparam logic [7:0] cmdtype_access_reg = 8'd0;

  typedef enum logic [2:0] {
    cmderr_none          = 3'd0,
    cmderr_not_supported = 3'd2,
    cmderr_exception     = 3'd3,
    cmderr_halt_resume   = 3'd4
  } cmderr_e;

  // --------------------------------------------------
  // instruction encodings
  // --------------------------------------------------
  // jal x0, imm (imm is a byte offset)
  function automatic logic [31:0] jal_x0(logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, 7'h6f};
  endfunction

  // lw rd, data_addr(x0)
  function automatic logic [31:0] load_w(logic [4:0] rd);
    return {data_addr, 5'd0, 3'b010, rd, 7'h03};
  endfunction

  // sw rs2, data_addr(x0)
  function automatic logic [31:0] store_w(logic [4:0] rs2);
    return {data_addr[11:5], rs2, 5'd0, 3'b010, data_addr[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] ebreak();
    return 32'h0010_0073;
  endfunction

  // addi x0, x0, 0
  function automatic logic [31:0] nop();
    return 32'h0000_0013;
  endfunction

  function automatic logic [31:0] illegal();
    return 32'h0000_0000;
  endfunction

endpackage

// ==== src/dbg_cmd_fsm.sv ====
`timescale 1ns/1ps

module dbg_cmd_fsm (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 cmd_valid_i,
  input  logic                 unsupported_i,
  // status of the selected hart
  input  logic                 halted_sel_i,
  input  logic                 resuming_sel_i,
  input  logic                 haltreq_sel_i,
  input  logic                 resumereq_sel_i,
  // hart event pulses
  input  logic                 going_i,
  input  logic                 halted_event_sel_i,
  input  logic                 exception_i,
  output logic                 go_o,
  output logic                 resume_o,
  output logic                 cmdbusy_o,
  output logic                 cmderror_valid_o,
  output dbg_mem_pkg::cmderr_e cmderror_o
);

  typedef enum logic [1:0] {st_idle, st_go, st_resume, st_exec} state_e;

  state_e state_d, state_q;

  always_comb begin
    state_d          = state_q;
    go_o             = 1'b0;
    resume_o         = 1'b0;
    cmdbusy_o        = 1'b1;
    cmderror_valid_o = 1'b0;
    cmderror_o       = dbg_mem_pkg::cmderr_none;

    unique case (state_q)
      st_idle: begin
        cmdbusy_o = 1'b0;
        if (cmd_valid_i && halted_sel_i && !unsupported_i) begin
          state_d = st_go;
        end else if (cmd_valid_i) begin
          // commands only run on a halted hart
          cmderror_valid_o = 1'b1;
          cmderror_o       = dbg_mem_pkg::cmderr_halt_resume;
        end
        // resume is ignored while a halt is requested or the last ack is pending
        if (resumereq_sel_i && !resuming_sel_i && !haltreq_sel_i && halted_sel_i) begin
          state_d = st_resume;
        end
      end
      st_go: begin
        // flag byte tells the hart to jump via whereto
        go_o = 1'b1;
        if (going_i) begin
          state_d = st_exec;
        end
      end
      st_resume: begin
        resume_o = 1'b1;
        if (resuming_sel_i) begin
          state_d = st_idle;
        end
      end
      st_exec: begin
        // program ends with ebreak, hart parks and reports halted again
        if (halted_event_sel_i) begin
          state_d = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase

    // reported once, on the command itself
    if (unsupported_i && cmd_valid_i) begin
      cmderror_valid_o = 1'b1;
      cmderror_o       = dbg_mem_pkg::cmderr_not_supported;
    end
    if (exception_i) begin
      cmderror_valid_o = 1'b1;
      cmderror_o       = dbg_mem_pkg::cmderr_exception;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // harts only report going after they saw the go flag
  a_going_in_go: assert property (@(posedge clk_i) disable iff (!rst_ni)
    going_i |-> go_o);

  // debugger waits for busy to drop before the next command
  a_cmd_when_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_valid_i |-> !cmdbusy_o);

endmodule

// ==== src/dbg_hart_status.sv ====
`timescale 1ns/1ps

module dbg_hart_status (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic [dbg_mem_pkg::hartsel_w-1:0] hartsel_i,
  // hart named in the written data
  input  logic [dbg_mem_pkg::hartsel_w-1:0] hart_idx_i,
  input  logic                              halted_set_i,
  input  logic                              resuming_set_i,
  input  logic                              clear_resumeack_i,
  output logic [dbg_mem_pkg::nr_harts-1:0]  halted_o,
  output logic [dbg_mem_pkg::nr_harts-1:0]  resuming_o
);

  logic [dbg_mem_pkg::nr_harts-1:0] halted_d, resuming_d;

  always_comb begin
    halted_d   = halted_o;
    resuming_d = resuming_o;
    // debugger acks the resume of the selected hart
    if (clear_resumeack_i) begin
      resuming_d[hartsel_i] = 1'b0;
    end
    if (halted_set_i) begin
      halted_d[hart_idx_i] = 1'b1;
    end
    // hart left the park loop
    if (resuming_set_i) begin
      halted_d[hart_idx_i]   = 1'b0;
      resuming_d[hart_idx_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      halted_o   <= '0;
      resuming_o <= '0;
    end else begin
      halted_o   <= halted_d;
      resuming_o <= resuming_d;
    end
  end

  // only a parked hart can report that it resumes
  a_resume_from_halt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resuming_set_i |-> halted_o[hart_idx_i]);

endmodule

// ==== src/dbg_abstract_cmd.sv ====
`timescale 1ns/1ps

module dbg_abstract_cmd (
  input  dbg_mem_pkg::cmd_t cmd_i,
  input  logic [3:0]        word_idx_i,
  output logic [31:0]       word_o,
  output logic              unsupported_o
);

  dbg_mem_pkg::ac_ar_cmd_t ac_ar;
  logic [31:0]             prog [dbg_mem_pkg::abs_cmd_words];
  logic                    gpr_ok;

  assign ac_ar = dbg_mem_pkg::ac_ar_cmd_t'(cmd_i.control);

  // 32-bit integer register, regno 0x1000..0x101f
  assign gpr_ok = (ac_ar.regno[15:14] == 2'b00) && ac_ar.regno[12] && !ac_ar.regno[5];

  always_comb begin
    unsupported_o = 1'b0;
    // default program traps straight away
    prog[0] = dbg_mem_pkg::illegal();
    for (int i = 1; i < dbg_mem_pkg::abs_cmd_words - 1; i++) begin
      prog[i] = dbg_mem_pkg::nop();
    end
    prog[dbg_mem_pkg::abs_cmd_words-1] = dbg_mem_pkg::ebreak();

    // --------------------------------------------------
    // access register
    // --------------------------------------------------
    if (cmd_i.cmdtype == dbg_mem_pkg::cmdtype_access_reg &&
        ac_ar.aarsize == 3'd2 && !ac_ar.aarpostincrement &&
        (!ac_ar.transfer || gpr_ok)) begin
      if (ac_ar.transfer) begin
        prog[0] = dbg_mem_pkg::nop();
        // write moves data0 into the register, read the other way
        if (ac_ar.write) begin
          prog[1] = dbg_mem_pkg::load_w(ac_ar.regno[4:0]);
        end else begin
          prog[1] = dbg_mem_pkg::store_w(ac_ar.regno[4:0]);
        end
      end
      // fall through into the program buffer
      if (ac_ar.postexec) begin
        prog[dbg_mem_pkg::abs_cmd_words-1] = dbg_mem_pkg::nop();
      end
    end else begin
      // leave at once
      prog[0]       = dbg_mem_pkg::ebreak();
      unsupported_o = 1'b1;
    end
  end

  // out of range words read as zero
  assign word_o = (word_idx_i < 4'(dbg_mem_pkg::abs_cmd_words)) ? prog[word_idx_i] : '0;

endmodule

// ==== src/dbg_mem_port.sv ====
`timescale 1ns/1ps

module dbg_mem_port (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  // hart side sram port
  input  logic                                       req_i,
  input  logic                                       we_i,
  input  logic [31:0]                                addr_i,
  input  logic [31:0]                                wdata_i,
  input  logic [3:0]                                 be_i,
  output logic [31:0]                                rdata_o,
  // debugger side
  input  logic [dbg_mem_pkg::data_count-1:0][31:0]   data_i,
  input  logic [dbg_mem_pkg::progbuf_size-1:0][31:0] progbuf_i,
  input  dbg_mem_pkg::cmd_t                          cmd_i,
  input  logic [dbg_mem_pkg::hartsel_w-1:0]          hartsel_i,
  output logic [dbg_mem_pkg::data_count-1:0][31:0]   data_o,
  output logic                                       data_valid_o,
  // command state
  input  logic                                       cmdbusy_i,
  input  logic                                       go_i,
  input  logic                                       resume_i,
  input  logic [dbg_mem_pkg::nr_harts-1:0]           resumereq_i,
  // abstract command program lookup
  input  logic [31:0]                                abs_word_i,
  output logic [3:0]                                 abs_idx_o,
  // hart event pulses
  output logic [dbg_mem_pkg::hartsel_w-1:0]          hart_idx_o,
  output logic                                       halted_set_o,
  output logic                                       resuming_set_o,
  output logic                                       going_o,
  output logic                                       exception_o
);

  localparam int data_idx_w = $clog2(dbg_mem_pkg::data_count);
  localparam int pb_idx_w   = $clog2(dbg_mem_pkg::progbuf_size);

  dbg_mem_pkg::ac_ar_cmd_t                ac_ar;
  logic [dbg_mem_pkg::dbg_addr_w-1:0] addr;
  logic [dbg_mem_pkg::dbg_addr_w-1:0] data_off, pb_off, abs_off;
  logic [dbg_mem_pkg::dbg_addr_w-1:0] flag_word;
  logic [31:0]                        rdata_d, rdata_q;

  assign addr       = addr_i[dbg_mem_pkg::dbg_addr_w-1:0];
  assign ac_ar      = dbg_mem_pkg::ac_ar_cmd_t'(cmd_i.control);
  // harts write their own id with the event
  assign hart_idx_o = wdata_i[dbg_mem_pkg::hartsel_w-1:0];

  // window offsets
  assign data_off   = addr - dbg_mem_pkg::data_addr;
  assign pb_off     = addr - dbg_mem_pkg::progbuf_addr;
  assign abs_off    = addr - dbg_mem_pkg::abs_cmd_addr;
  assign abs_idx_o  = abs_off[5:2];
  assign flag_word  = {addr[dbg_mem_pkg::dbg_addr_w-1:2], 2'b00} - dbg_mem_pkg::flags_addr;

  // --------------------------------------------------
  // hart writes
  // --------------------------------------------------
  always_comb begin
    halted_set_o   = 1'b0;
    resuming_set_o = 1'b0;
    going_o        = 1'b0;
    exception_o    = 1'b0;
    data_valid_o   = 1'b0;
    data_o         = data_i;
    if (req_i && we_i) begin
      case (addr) inside
        dbg_mem_pkg::halted_addr:    halted_set_o   = 1'b1;
        dbg_mem_pkg::going_addr:     going_o        = 1'b1;
        dbg_mem_pkg::resuming_addr:  resuming_set_o = 1'b1;
        dbg_mem_pkg::exception_addr: exception_o    = 1'b1;
        [dbg_mem_pkg::data_addr:dbg_mem_pkg::data_end]: begin
          data_valid_o = 1'b1;
          // enabled bytes over the debugger's copy
          for (int i = 0; i < 4; i++) begin
            if (be_i[i]) begin
              data_o[data_off[2 +: data_idx_w]][i*8 +: 8] = wdata_i[i*8 +: 8];
            end
          end
        end
        default: ;
      endcase
    end
  end

  // --------------------------------------------------
  // hart reads
  // --------------------------------------------------
  always_comb begin
    rdata_d = rdata_q;
    if (req_i && !we_i) begin
      rdata_d = '0;
      case (addr) inside
        dbg_mem_pkg::whereto_addr: begin
          if (resumereq_i[hart_idx_o]) begin
            rdata_d = dbg_mem_pkg::jal_x0(21'(dbg_mem_pkg::resume_addr) -
                                          21'(dbg_mem_pkg::whereto_addr));
          end
          if (cmdbusy_i) begin
            // no transfer plus postexec skips the command program
            if (cmd_i.cmdtype == dbg_mem_pkg::cmdtype_access_reg &&
                !ac_ar.transfer && ac_ar.postexec) begin
              rdata_d = dbg_mem_pkg::jal_x0(21'(dbg_mem_pkg::progbuf_addr) -
                                            21'(dbg_mem_pkg::whereto_addr));
            end else begin
              rdata_d = dbg_mem_pkg::jal_x0(21'(dbg_mem_pkg::abs_cmd_addr) -
                                            21'(dbg_mem_pkg::whereto_addr));
            end
          end
        end
        [dbg_mem_pkg::data_addr:dbg_mem_pkg::data_end]:
          rdata_d = data_i[data_off[2 +: data_idx_w]];
        [dbg_mem_pkg::progbuf_addr:dbg_mem_pkg::progbuf_end]:
          rdata_d = progbuf_i[pb_off[2 +: pb_idx_w]];
        [dbg_mem_pkg::abs_cmd_addr:dbg_mem_pkg::abs_cmd_end]:
          rdata_d = abs_word_i;
        // harts poll here, only the selected one sees go or resume
        [dbg_mem_pkg::flags_addr:dbg_mem_pkg::flags_end]: begin
          // all four flag bytes share the word at flags_addr
          if (flag_word == '0) begin
            rdata_d[8*hartsel_i[1:0] +: 8] = {6'b0, resume_i, go_i};
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== src/dbg_mem_top.sv ====
`timescale 1ns/1ps

module dbg_mem_top (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  // hart side sram port
  input  logic                                       req_i,
  input  logic                                       we_i,
  input  logic [31:0]                                addr_i,
  input  logic [31:0]                                wdata_i,
  input  logic [3:0]                                 be_i,
  output logic [31:0]                                rdata_o,
  // debugger side
  input  logic [19:0]                                hartsel_i,
  input  logic [dbg_mem_pkg::nr_harts-1:0]           haltreq_i,
  input  logic [dbg_mem_pkg::nr_harts-1:0]           resumereq_i,
  input  logic                                       clear_resumeack_i,
  input  logic                                       cmd_valid_i,
  input  dbg_mem_pkg::cmd_t                          cmd_i,
  input  logic [dbg_mem_pkg::data_count-1:0][31:0]   data_i,
  input  logic [dbg_mem_pkg::progbuf_size-1:0][31:0] progbuf_i,
  output logic [dbg_mem_pkg::nr_harts-1:0]           debug_req_o,
  output logic [dbg_mem_pkg::nr_harts-1:0]           halted_o,
  output logic [dbg_mem_pkg::nr_harts-1:0]           resuming_o,
  output logic [dbg_mem_pkg::data_count-1:0][31:0]   data_o,
  output logic                                       data_valid_o,
  output logic                                       cmderror_valid_o,
  output dbg_mem_pkg::cmderr_e                       cmderror_o,
  output logic                                       cmdbusy_o
);

  logic [dbg_mem_pkg::hartsel_w-1:0] hartsel, hart_idx;
  logic        halted_set, resuming_set, going, exception;
  logic        go, resume, unsupported;
  logic [3:0]  abs_idx;
  logic [31:0] abs_word;
  // selected hart view
  logic        halted_sel, resuming_sel, haltreq_sel, resumereq_sel, halted_event_sel;

  assign debug_req_o      = haltreq_i;
  assign hartsel          = hartsel_i[dbg_mem_pkg::hartsel_w-1:0];
  assign halted_sel       = halted_o[hartsel];
  assign resuming_sel     = resuming_o[hartsel];
  assign haltreq_sel      = haltreq_i[hartsel];
  assign resumereq_sel    = resumereq_i[hartsel];
  assign halted_event_sel = halted_set && (hart_idx == hartsel);

  dbg_cmd_fsm u_fsm (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .cmd_valid_i        (cmd_valid_i),
    .unsupported_i      (unsupported),
    .halted_sel_i       (halted_sel),
    .resuming_sel_i     (resuming_sel),
    .haltreq_sel_i      (haltreq_sel),
    .resumereq_sel_i    (resumereq_sel),
    .going_i            (going),
    .halted_event_sel_i (halted_event_sel),
    .exception_i        (exception),
    .go_o               (go),
    .resume_o           (resume),
    .cmdbusy_o          (cmdbusy_o),
    .cmderror_valid_o   (cmderror_valid_o),
    .cmderror_o         (cmderror_o)
  );

  dbg_hart_status u_status (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .hartsel_i         (hartsel),
    .hart_idx_i        (hart_idx),
    .halted_set_i      (halted_set),
    .resuming_set_i    (resuming_set),
    .clear_resumeack_i (clear_resumeack_i),
    .halted_o          (halted_o),
    .resuming_o        (resuming_o)
  );

  dbg_abstract_cmd u_abs (
    .cmd_i         (cmd_i),
    .word_idx_i    (abs_idx),
    .word_o        (abs_word),
    .unsupported_o (unsupported)
  );

  dbg_mem_port u_port (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .we_i           (we_i),
    .addr_i         (addr_i),
    .wdata_i        (wdata_i),
    .be_i           (be_i),
    .rdata_o        (rdata_o),
    .data_i         (data_i),
    .progbuf_i      (progbuf_i),
    .cmd_i          (cmd_i),
    .hartsel_i      (hartsel),
    .data_o         (data_o),
    .data_valid_o   (data_valid_o),
    .cmdbusy_i      (cmdbusy_o),
    .go_i           (go),
    .resume_i       (resume),
    .resumereq_i    (resumereq_i),
    .abs_word_i     (abs_word),
    .abs_idx_o      (abs_idx),
    .hart_idx_o     (hart_idx),
    .halted_set_o   (halted_set),
    .resuming_set_o (resuming_set),
    .going_o        (going),
    .exception_o    (exception)
  );

endmodule

// ==== tb/tb_dbg_mem.sv ====
`timescale 1ns/1ps

module tb_dbg_mem;

  localparam int    period_ns  = 40;
  localparam string stim_file  = "tb/dbg_mem_stim.txt";

  logic                                       clk_i;
  logic                                       rst_ni;
  logic                                       req_i;
  logic                                       we_i;
  logic [31:0]                                addr_i;
  logic [31:0]                                wdata_i;
  logic [3:0]                                 be_i;
  logic [31:0]                                rdata_o;
  logic [19:0]                                hartsel_i;
  logic [dbg_mem_pkg::nr_harts-1:0]           haltreq_i;
  logic [dbg_mem_pkg::nr_harts-1:0]           resumereq_i;
  logic                                       clear_resumeack_i;
  logic                                       cmd_valid_i;
  dbg_mem_pkg::cmd_t                          cmd_i;
  logic [dbg_mem_pkg::data_count-1:0][31:0]   data_i;
  logic [dbg_mem_pkg::progbuf_size-1:0][31:0] progbuf_i;
  logic [dbg_mem_pkg::nr_harts-1:0]           debug_req_o;
  logic [dbg_mem_pkg::nr_harts-1:0]           halted_o;
  logic [dbg_mem_pkg::nr_harts-1:0]           resuming_o;
  logic [dbg_mem_pkg::data_count-1:0][31:0]   data_o;
  logic                                       data_valid_o;
  logic                                       cmderror_valid_o;
  dbg_mem_pkg::cmderr_e                       cmderror_o;
  logic                                       cmdbusy_o;

  // one entry per stim line
  string       name_q[$];
  string       kind_q[$];
  logic [31:0] a_q[$];
  logic [31:0] b_q[$];
  logic [31:0] c_q[$];
  logic [31:0] sel_q[$];
  logic [31:0] exp_q[$];

  int checks      = 0;
  int errors      = 0;
  int cycles      = 0;
  // raised once the stim file is loaded
  int cycle_limit = 1000;

  dbg_mem_top u_dut (.*);

  initial clk_i = 1'b0;
  always #(period_ns / 2) clk_i = ~clk_i;

  // --------------------------------------------------
  // timeout
  // --------------------------------------------------
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic load_stim();
    int          fd;
    int          code;
    string       tok;
    string       kind;
    string       line;
    logic [31:0] a, b, c, s, e;
    fd = $fopen(stim_file, "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file %s", stim_file);
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", tok);
        if (code != 1) break;
        // comment lines start with a lone #
        if (tok == "#") begin
          code = $fgets(line, fd);
        end else begin
          code = $fscanf(fd, "%s %h %h %h %h %h", kind, a, b, c, s, e);
          name_q.push_back(tok);
          kind_q.push_back(kind);
          a_q.push_back(a);
          b_q.push_back(b);
          c_q.push_back(c);
          sel_q.push_back(s);
          exp_q.push_back(e);
        end
      end
      $fclose(fd);
    end
  endtask

  // debugger side inputs, by field code
  task automatic set_input(input logic [31:0] field, input logic [31:0] value);
    case (field)
      32'h0:  hartsel_i         = value[19:0];
      32'h1:  haltreq_i         = value[dbg_mem_pkg::nr_harts-1:0];
      32'h2:  resumereq_i       = value[dbg_mem_pkg::nr_harts-1:0];
      32'h3:  clear_resumeack_i = value[0];
      32'h4:  data_i[0]         = value;
      32'h5:  data_i[1]         = value;
      32'h6:  progbuf_i[0]      = value;
      32'h7:  progbuf_i[1]      = value;
      32'h8:  progbuf_i[2]      = value;
      32'h9:  progbuf_i[3]      = value;
      32'hff: ;
      default: begin
        errors++;
        $display("unknown debugger input code %0h in the stimulus file", field);
      end
    endcase
  endtask

  // output picked by the chk column
  function automatic logic [31:0] observe(input logic [31:0] sel);
    logic [31:0] val;
    case (sel)
      32'h1:   val = rdata_o;
      32'h2:   val = 32'(halted_o);
      32'h3:   val = 32'(resuming_o);
      32'h4:   val = 32'(cmdbusy_o);
      32'h5:   val = {28'd0, cmderror_valid_o, cmderror_o};
      32'h6:   val = data_o[0];
      32'h7:   val = data_o[1];
      32'h8:   val = 32'(data_valid_o);
      32'h9:   val = 32'(debug_req_o);
      default: val = '0;
    endcase
    return val;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("Error %s: expected %08h, actual %08h", name, exp, act);
    end
  endtask

  // --------------------------------------------------
  // one stim line, driven on the falling edge
  // --------------------------------------------------
  task automatic run_op(input int i);
    // single cycle pulses from the previous line end here
    @(negedge clk_i);
    req_i             = 1'b0;
    we_i              = 1'b0;
    cmd_valid_i       = 1'b0;
    clear_resumeack_i = 1'b0;
    if (kind_q[i] == "hwrite") begin
      req_i   = 1'b1;
      we_i    = 1'b1;
      addr_i  = a_q[i];
      wdata_i = b_q[i];
      be_i    = c_q[i][3:0];
    end else if (kind_q[i] == "hread") begin
      // wdata carries the hart id for whereto
      req_i   = 1'b1;
      addr_i  = a_q[i];
      wdata_i = b_q[i];
      be_i    = 4'hf;
      @(negedge clk_i);
      req_i   = 1'b0;
    end else if (kind_q[i] == "cmd") begin
      cmd_valid_i = 1'b1;
      cmd_i       = dbg_mem_pkg::cmd_t'(a_q[i]);
    end else if (kind_q[i] == "dbg") begin
      set_input(a_q[i], b_q[i]);
    end else begin
      errors++;
      $display("unknown operation %s on stimulus line %s", kind_q[i], name_q[i]);
    end
    // halfway to the rising edge, outputs are settled
    #(period_ns / 4);
    if (sel_q[i] != 0) begin
      check_value(name_q[i], exp_q[i], observe(sel_q[i]));
    end
  endtask

  initial begin
    rst_ni            = 1'b0;
    req_i             = 1'b0;
    we_i              = 1'b0;
    addr_i            = '0;
    wdata_i           = '0;
    be_i              = '0;
    hartsel_i         = '0;
    haltreq_i         = '0;
    resumereq_i       = '0;
    clear_resumeack_i = 1'b0;
    cmd_valid_i       = 1'b0;
    cmd_i             = '0;
    data_i            = '0;
    progbuf_i         = '0;
    load_stim();
    if (name_q.size() == 0) begin
      $display("no operations were read from %s", stim_file);
      $display("Test FAILED");
      $finish;
    end else begin
      cycle_limit = 20 * name_q.size();
      repeat (3) @(posedge clk_i);
      @(negedge clk_i);
      rst_ni = 1'b1;
      for (int i = 0; i < name_q.size(); i++) begin
        run_op(i);
      end
      @(negedge clk_i);
      req_i             = 1'b0;
      cmd_valid_i       = 1'b0;
      clear_resumeack_i = 1'b0;
      repeat (2) @(negedge clk_i);
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
        $display("Test OK");
      end else begin
        $display("Test FAILED");
      end
      $finish;
    end
  end

endmodule

// ==== tb/dbg_mem_stim.txt ====
# columns: name op a b c chk exp, hex; hwrite a=addr b=wdata c=be, hread a=addr b=hart id
# cmd a=command, dbg a=input b=value; chk 1 rdata 2 halted 3 resuming 4 busy 5 err 9 dreq
halt_dreq    dbg    1      2        0 9 2
halt_sel     dbg    0      1        0 0 0
err_halt     cmd    231005 0        0 5 c
halt_write   hwrite 100    1        f 0 0
halt_status  dbg    ff     0        0 2 2
halt_dclr    dbg    1      0        0 9 0
data_set     dbg    4      a5a5a5a5 0 0 0
data_read    hread  380    1        0 1 a5a5a5a5
data_merge   hwrite 380    1234     3 6 a5a51234
data_valid   hwrite 384    ff       1 8 1
cmd_issue    cmd    231005 0        0 5 0
cmd_busy     dbg    ff     0        0 4 1
cmd_goflag   hread  400    1        0 1 100
cmd_whereto  hread  300    1        0 1 0480006f
cmd_word1    hread  34c    1        0 1 38002283
cmd_going    hwrite 104    1        f 4 1
cmd_halted   hwrite 100    1        f 4 1
cmd_done     dbg    ff     0        0 4 0
err_unsup    cmd    331005 0        0 5 a
err_except   hwrite 10c    1        f 5 b
pb_set       dbg    8      deadbeef 0 0 0
pb_read      hread  378    1        0 1 deadbeef
pb_cmd       cmd    240000 0        0 5 0
pb_whereto   hread  300    1        0 1 0700006f
pb_going     hwrite 104    1        f 0 0
pb_halted    hwrite 100    1        f 0 0
pb_done      dbg    ff     0        0 4 0
res_hold     dbg    1      2        0 0 0
res_req      dbg    2      2        0 4 0
res_whereto  hread  300    1        0 1 5080006f
res_release  dbg    1      0        0 0 0
res_flag     hread  400    1        0 1 200
res_write    hwrite 108    1        f 0 0
res_halted   dbg    ff     0        0 2 0
res_resuming dbg    ff     0        0 3 2
res_reqclr   dbg    2      0        0 0 0
res_clear    dbg    3      1        0 0 0
res_acked    dbg    ff     0        0 3 0

// ==== compile.f ====
common/dbg_mem_pkg.sv
src/dbg_cmd_fsm.sv
src/dbg_hart_status.sv
src/dbg_abstract_cmd.sv
src/dbg_mem_port.sv
src/dbg_mem_top.sv
tb/tb_dbg_mem.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dbg_mem
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
